// File: hdl/obb_pkg.sv
package obb_pkg;

    // Fixed-point formats
    localparam int POS_W      = 22;  // Q8.14
    localparam int AXIS_W     = 16;  // Q2.14
    localparam int PROJ_W     = 32;  // Q8.24
    localparam int POS_FRAC   = 14;
    localparam int AXIS_FRAC  = 14;
    localparam int PROJ_FRAC  = 24;
    localparam int PROJ_SHIFT = 18;

    // Corner offset from the reference centre carries POS_FRAC + AXIS_FRAC fraction bits
    localparam int REL_W = 40;
    localparam int DOT_W = REL_W + AXIS_W + 1;

    localparam int FIFO_DEPTH = 2;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    // APB register map
    localparam int APB_ADDR_W = 12;
    localparam int APB_DATA_W = 32;
    localparam int BOX_WORDS  = 6;
    localparam logic [APB_ADDR_W-1:0] ADDR_CTRL   = 12'h000;
    localparam logic [APB_ADDR_W-1:0] ADDR_STATUS = 12'h004;
    localparam logic [APB_ADDR_W-1:0] ADDR_BOX_A  = 12'h008;
    localparam logic [APB_ADDR_W-1:0] ADDR_BOX_B  = 12'h020;
    localparam logic [APB_ADDR_W-1:0] ADDR_FLAGS  = 12'h038;
    localparam logic [APB_ADDR_W-1:0] ADDR_DEPTH  = 12'h03C;
    localparam logic [APB_ADDR_W-1:0] ADDR_NORMAL = 12'h040;

    typedef struct packed {
        logic signed [POS_W-1:0] x;
        logic signed [POS_W-1:0] y;
    } vec_pos_t;

    typedef struct packed {
        logic signed [AXIS_W-1:0] x;
        logic signed [AXIS_W-1:0] y;
    } vec_axis_t;

    typedef struct packed {
        vec_pos_t                centre;
        vec_axis_t               u;
        logic signed [POS_W-1:0] half_w;
        logic signed [POS_W-1:0] half_h;
    } box_t;

    // Extents of one pass plus the size and axis of the box projected onto
    typedef struct packed {
        logic signed [PROJ_W-1:0] min_u;
        logic signed [PROJ_W-1:0] max_u;
        logic signed [PROJ_W-1:0] min_v;
        logic signed [PROJ_W-1:0] max_v;
        logic signed [POS_W-1:0]  half_w;
        logic signed [POS_W-1:0]  half_h;
        vec_axis_t                u;
    } extent_t;

    typedef struct packed {
        logic                     collision;
        logic signed [PROJ_W-1:0] depth;
        vec_axis_t                normal;
    } result_t;

    // Second box axis is u turned a quarter turn counter-clockwise
    function automatic vec_axis_t rot90(vec_axis_t a);
        vec_axis_t r;
        r.x = -a.y;
        r.y = a.x;
        return r;
    endfunction

endpackage

// File: hdl/obb_apb_regs.sv
`timescale 1ns/1ps

module obb_apb_regs
    import obb_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic [APB_DATA_W-1:0] pwdata,
    input  result_t               res,
    input  logic                  res_valid,
    output logic [APB_DATA_W-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr,
    output box_t                  box_a,
    output box_t                  box_b,
    output logic                  start
);

    logic                  access;
    logic                  addr_ok;
    logic                  hit_a;
    logic                  hit_b;
    logic                  ctrl_go;
    logic [APB_ADDR_W-1:0] off_a;
    logic [APB_ADDR_W-1:0] off_b;
    logic                  busy;
    logic                  done;
    result_t               res_q;

    function automatic logic [APB_DATA_W-1:0] ext_pos(logic [POS_W-1:0] v);
        return {{(APB_DATA_W-POS_W){v[POS_W-1]}}, v};
    endfunction

    function automatic logic [APB_DATA_W-1:0] ext_axis(logic [AXIS_W-1:0] v);
        return {{(APB_DATA_W-AXIS_W){v[AXIS_W-1]}}, v};
    endfunction

    // Word order inside a box block is pos_x, pos_y, u_x, u_y, half_w, half_h
    function automatic logic [APB_DATA_W-1:0] box_word(box_t b, logic [2:0] idx);
        case (idx)
            3'd0:    return ext_pos(b.centre.x);
            3'd1:    return ext_pos(b.centre.y);
            3'd2:    return ext_axis(b.u.x);
            3'd3:    return ext_axis(b.u.y);
            3'd4:    return ext_pos(b.half_w);
            default: return ext_pos(b.half_h);
        endcase
    endfunction

    function automatic box_t box_write(box_t b, logic [2:0] idx, logic [APB_DATA_W-1:0] d);
        box_t r;
        r = b;
        case (idx)
            3'd0:    r.centre.x = d[POS_W-1:0];
            3'd1:    r.centre.y = d[POS_W-1:0];
            3'd2:    r.u.x = d[AXIS_W-1:0];
            3'd3:    r.u.y = d[AXIS_W-1:0];
            3'd4:    r.half_w = d[POS_W-1:0];
            default: r.half_h = d[POS_W-1:0];
        endcase
        return r;
    endfunction

    assign access = psel && penable;
    assign off_a  = paddr - ADDR_BOX_A;
    assign off_b  = paddr - ADDR_BOX_B;
    assign hit_a  = (paddr >= ADDR_BOX_A) && (off_a < APB_ADDR_W'(4 * BOX_WORDS));
    assign hit_b  = (paddr >= ADDR_BOX_B) && (off_b < APB_ADDR_W'(4 * BOX_WORDS));

    assign addr_ok = (paddr[1:0] == 2'b00) &&
                     (hit_a || hit_b || paddr == ADDR_CTRL || paddr == ADDR_STATUS ||
                      paddr == ADDR_FLAGS || paddr == ADDR_DEPTH || paddr == ADDR_NORMAL);

    assign pready  = 1'b1;
    assign pslverr = access && !addr_ok;

    // A start request while a check runs is dropped
    assign ctrl_go = access && pwrite && paddr == ADDR_CTRL && pwdata[0] && !busy;

    always_comb begin
        prdata = '0;
        if (psel && !pwrite && addr_ok) begin
            if (hit_a) begin
                prdata = box_word(box_a, off_a[4:2]);
            end else if (hit_b) begin
                prdata = box_word(box_b, off_b[4:2]);
            end else begin
                case (paddr)
                    ADDR_STATUS: prdata = APB_DATA_W'({done, busy});
                    ADDR_FLAGS:  prdata = APB_DATA_W'(res_q.collision);
                    ADDR_DEPTH:  prdata = res_q.depth;
                    ADDR_NORMAL: prdata = {res_q.normal.y, res_q.normal.x};
                    default:     prdata = '0;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access && pwrite && addr_ok) begin
            if (hit_a) begin
                box_a <= box_write(box_a, off_a[4:2], pwdata);
            end
            if (hit_b) begin
                box_b <= box_write(box_b, off_b[4:2], pwdata);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            start <= 1'b0;
            busy  <= 1'b0;
            done  <= 1'b0;
            res_q <= '0;
        end else begin
            start <= ctrl_go;
            if (ctrl_go) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (res_valid && busy) begin
                busy  <= 1'b0;
                done  <= 1'b1;
                res_q <= res;
            end
        end
    end

endmodule

// File: hdl/corner_projector.sv
`timescale 1ns/1ps

module corner_projector
    import obb_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    start,
    input  box_t    box_a,
    input  box_t    box_b,
    input  logic    ext_in_ready,
    output extent_t ext_in,
    output logic    ext_in_valid
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PROJ,
        ST_OFFER
    } state_t;

    state_t                         state;
    logic                           pass;    // 0 projects A onto B, 1 projects B onto A
    logic [1:0]                     corner;
    box_t                           mov_box;
    box_t                           ref_box;
    vec_axis_t                      mov_v;
    vec_axis_t                      ref_v;
    logic signed [POS_W:0]          dx;
    logic signed [POS_W:0]          dy;
    logic signed [POS_W+AXIS_W-1:0] wx;
    logic signed [POS_W+AXIS_W-1:0] wy;
    logic signed [POS_W+AXIS_W-1:0] hx;
    logic signed [POS_W+AXIS_W-1:0] hy;
    logic signed [REL_W-1:0]        rel_x;
    logic signed [REL_W-1:0]        rel_y;
    logic signed [DOT_W-1:0]        dot_u;
    logic signed [DOT_W-1:0]        dot_v;
    logic signed [PROJ_W-1:0]       proj_u;
    logic signed [PROJ_W-1:0]       proj_v;
    extent_t                        ext_q;

    always_comb begin
        mov_box = pass ? box_b : box_a;
        ref_box = pass ? box_a : box_b;
        mov_v   = rot90(mov_box.u);
        ref_v   = rot90(ref_box.u);
    end

    // Corner relative to the reference centre at full product precision
    always_comb begin
        dx = (POS_W+1)'(mov_box.centre.x) - (POS_W+1)'(ref_box.centre.x);
        dy = (POS_W+1)'(mov_box.centre.y) - (POS_W+1)'(ref_box.centre.y);
        wx = (POS_W+AXIS_W)'(mov_box.half_w) * (POS_W+AXIS_W)'(mov_box.u.x);
        wy = (POS_W+AXIS_W)'(mov_box.half_w) * (POS_W+AXIS_W)'(mov_box.u.y);
        hx = (POS_W+AXIS_W)'(mov_box.half_h) * (POS_W+AXIS_W)'(mov_v.x);
        hy = (POS_W+AXIS_W)'(mov_box.half_h) * (POS_W+AXIS_W)'(mov_v.y);

        rel_x = REL_W'(dx) <<< AXIS_FRAC;
        rel_y = REL_W'(dy) <<< AXIS_FRAC;

        // Corners walk (+w,+h), (-w,+h), (-w,-h), (+w,-h)
        if (corner[0] ^ corner[1]) begin
            rel_x = rel_x - REL_W'(wx);
            rel_y = rel_y - REL_W'(wy);
        end else begin
            rel_x = rel_x + REL_W'(wx);
            rel_y = rel_y + REL_W'(wy);
        end
        if (corner[1]) begin
            rel_x = rel_x - REL_W'(hx);
            rel_y = rel_y - REL_W'(hy);
        end else begin
            rel_x = rel_x + REL_W'(hx);
            rel_y = rel_y + REL_W'(hy);
        end

        dot_u  = DOT_W'(rel_x) * DOT_W'(ref_box.u.x) + DOT_W'(rel_y) * DOT_W'(ref_box.u.y);
        dot_v  = DOT_W'(rel_x) * DOT_W'(ref_v.x) + DOT_W'(rel_y) * DOT_W'(ref_v.y);
        proj_u = PROJ_W'(dot_u >>> PROJ_SHIFT);
        proj_v = PROJ_W'(dot_v >>> PROJ_SHIFT);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= ST_IDLE;
            pass   <= 1'b0;
            corner <= 2'd0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state  <= ST_PROJ;
                        pass   <= 1'b0;
                        corner <= 2'd0;
                    end
                end
                ST_PROJ: begin
                    corner <= corner + 2'd1;
                    if (corner == 2'd3) begin
                        state <= ST_OFFER;
                    end
                end
                ST_OFFER: begin
                    if (ext_in_ready) begin
                        if (pass) begin
                            state <= ST_IDLE;
                        end else begin
                            pass  <= 1'b1;
                            state <= ST_PROJ;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // The first corner seeds the running extents together with the reference data
    always_ff @(posedge clk) begin
        if (state == ST_PROJ) begin
            if (corner == 2'd0) begin
                ext_q.min_u  <= proj_u;
                ext_q.max_u  <= proj_u;
                ext_q.min_v  <= proj_v;
                ext_q.max_v  <= proj_v;
                ext_q.half_w <= ref_box.half_w;
                ext_q.half_h <= ref_box.half_h;
                ext_q.u      <= ref_box.u;
            end else begin
                if (proj_u < ext_q.min_u) ext_q.min_u <= proj_u;
                if (proj_u > ext_q.max_u) ext_q.max_u <= proj_u;
                if (proj_v < ext_q.min_v) ext_q.min_v <= proj_v;
                if (proj_v > ext_q.max_v) ext_q.max_v <= proj_v;
            end
        end
    end

    assign ext_in       = ext_q;
    assign ext_in_valid = (state == ST_OFFER);

endmodule

// File: hdl/extent_fifo.sv
`timescale 1ns/1ps

module extent_fifo
    import obb_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  extent_t ext_in,
    input  logic    ext_in_valid,
    input  logic    ext_out_ready,
    output logic    ext_in_ready,
    output extent_t ext_out,
    output logic    ext_out_valid
);

    extent_t               mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W:0]   count;
    logic                  push;
    logic                  pop;

    function automatic logic [FIFO_PTR_W-1:0] next_ptr(logic [FIFO_PTR_W-1:0] p);
        if (p == FIFO_PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return p + FIFO_PTR_W'(1);
    endfunction

    assign ext_in_ready  = count < (FIFO_PTR_W + 1)'(FIFO_DEPTH);
    assign ext_out_valid = count != '0;
    assign push          = ext_in_valid && ext_in_ready;
    assign pop           = ext_out_valid && ext_out_ready;
    assign ext_out       = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= ext_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop) rd_ptr <= next_ptr(rd_ptr);
            if (push && !pop) begin
                count <= count + (FIFO_PTR_W + 1)'(1);
            end else if (pop && !push) begin
                count <= count - (FIFO_PTR_W + 1)'(1);
            end
        end
    end

endmodule

// File: hdl/penetration_resolver.sv
`timescale 1ns/1ps

module penetration_resolver
    import obb_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  extent_t ext_out,
    input  logic    ext_out_valid,
    output logic    ext_out_ready,
    output result_t res,
    output logic    res_valid
);

    logic signed [PROJ_W-1:0] hw_ext;
    logic signed [PROJ_W-1:0] hh_ext;
    vec_axis_t                v_axis;
    logic signed [PROJ_W-1:0] pen [4];
    vec_axis_t                nrm [4];
    logic signed [PROJ_W-1:0] cand_depth;
    vec_axis_t                cand_normal;
    logic                     take;
    logic                     have_a;    // A pass result is waiting for the B pass
    logic signed [PROJ_W-1:0] a_depth;
    vec_axis_t                a_normal;

    // Half sizes brought up from Q8.14 to Q8.24
    always_comb begin
        hw_ext = PROJ_W'(ext_out.half_w) <<< (PROJ_FRAC - POS_FRAC);
        hh_ext = PROJ_W'(ext_out.half_h) <<< (PROJ_FRAC - POS_FRAC);
        v_axis = rot90(ext_out.u);

        pen[0]   = hw_ext - ext_out.min_u;
        nrm[0].x = -ext_out.u.x;
        nrm[0].y = -ext_out.u.y;
        pen[1]   = ext_out.max_u + hw_ext;
        nrm[1]   = ext_out.u;
        pen[2]   = hh_ext - ext_out.min_v;
        nrm[2].x = -v_axis.x;
        nrm[2].y = -v_axis.y;
        pen[3]   = ext_out.max_v + hh_ext;
        nrm[3]   = v_axis;

        // Strict compare keeps the earlier candidate on a tie
        cand_depth  = pen[0];
        cand_normal = nrm[0];
        for (int i = 1; i < 4; i++) begin
            if (pen[i] < cand_depth) begin
                cand_depth  = pen[i];
                cand_normal = nrm[i];
            end
        end
    end

    assign ext_out_ready = 1'b1;
    assign take          = ext_out_valid && ext_out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            have_a    <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= take && have_a;
            if (take) begin
                have_a <= !have_a;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && !have_a) begin
            a_depth  <= cand_depth;
            a_normal <= cand_normal;
        end
        if (take && have_a) begin
            // B pass wins only when strictly shallower
            if (cand_depth < a_depth) begin
                res.depth     <= cand_depth;
                res.normal    <= cand_normal;
                res.collision <= ~cand_depth[PROJ_W-1];
            end else begin
                res.depth     <= a_depth;
                res.normal    <= a_normal;
                res.collision <= ~a_depth[PROJ_W-1];
            end
        end
    end

endmodule

// File: hdl/collision_top.sv
`timescale 1ns/1ps

module collision_top
    import obb_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic [APB_DATA_W-1:0] pwdata,
    output logic [APB_DATA_W-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr
);

    box_t    box_a;
    box_t    box_b;
    logic    start;
    extent_t ext_in;
    logic    ext_in_valid;
    logic    ext_in_ready;
    extent_t ext_out;
    logic    ext_out_valid;
    logic    ext_out_ready;
    result_t res;
    logic    res_valid;

    obb_apb_regs regs_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .res       (res),
        .res_valid (res_valid),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .box_a     (box_a),
        .box_b     (box_b),
        .start     (start)
    );

    corner_projector projector_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .box_a        (box_a),
        .box_b        (box_b),
        .ext_in_ready (ext_in_ready),
        .ext_in       (ext_in),
        .ext_in_valid (ext_in_valid)
    );

    extent_fifo fifo_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .ext_in        (ext_in),
        .ext_in_valid  (ext_in_valid),
        .ext_out_ready (ext_out_ready),
        .ext_in_ready  (ext_in_ready),
        .ext_out       (ext_out),
        .ext_out_valid (ext_out_valid)
    );

    penetration_resolver resolver_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .ext_out       (ext_out),
        .ext_out_valid (ext_out_valid),
        .ext_out_ready (ext_out_ready),
        .res           (res),
        .res_valid     (res_valid)
    );

endmodule

// File: dv/collision_checker.sv
`timescale 1ns/1ps

module collision_checker
    import obb_pkg::*;
(
    input  logic                            clk,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [APB_ADDR_W-1:0]           paddr,
    input  logic [APB_DATA_W-1:0]           prdata,
    input  logic                            pready,
    input  logic                            pslverr,
    input  logic [2*BOX_WORDS-1:0][31:0]    exp_words,
    input  logic [2*BOX_WORDS-1:0]          exp_known,
    input  result_t                         exp_res,
    input  logic                            res_known,
    input  logic                            status_chk,
    input  logic [1:0]                      exp_status,
    output int                              pass_count,
    output int                              fail_count
);

    initial begin
        pass_count = 0;
        fail_count = 0;
    end

    // The map is one contiguous run of aligned words up to NORMAL
    function automatic logic addr_in_map(logic [APB_ADDR_W-1:0] a);
        return (a[1:0] == 2'b00) && (a <= ADDR_NORMAL);
    endfunction

    // Box word index 0..11 or -1 outside both box blocks
    function automatic int box_index(logic [APB_ADDR_W-1:0] a);
        if (a >= ADDR_BOX_A && a < ADDR_BOX_B) begin
            return int'(a - ADDR_BOX_A) / 4;
        end
        if (a >= ADDR_BOX_B && a < ADDR_FLAGS) begin
            return BOX_WORDS + int'(a - ADDR_BOX_B) / 4;
        end
        return -1;
    endfunction

    function automatic string reg_name(logic [APB_ADDR_W-1:0] a);
        int idx;
        idx = box_index(a);
        if (!addr_in_map(a)) begin
            return $sformatf("unmapped addr %03h", a);
        end
        if (idx >= 0) begin
            return $sformatf("BOX_%s[%0d]", (idx < BOX_WORDS) ? "A" : "B", idx % BOX_WORDS);
        end
        case (a)
            ADDR_CTRL:   return "CTRL";
            ADDR_STATUS: return "STATUS";
            ADDR_FLAGS:  return "FLAGS";
            ADDR_DEPTH:  return "DEPTH";
            default:     return "NORMAL";
        endcase
    endfunction

    task automatic compare(input string name, input logic [31:0] expv, input logic [31:0] actv);
        if (actv !== expv) begin
            $display("mismatch at %0t: %s expected %08h actual %08h", $time, name, expv, actv);
            fail_count = fail_count + 1;
        end else begin
            pass_count = pass_count + 1;
        end
    endtask

    // Access phase is sampled mid-cycle between the clock edges
    always @(negedge clk) begin
        int    idx;
        string name;
        if (psel && penable) begin
            idx  = box_index(paddr);
            name = reg_name(paddr);
            compare({name, " pready"}, 32'd1, 32'(pready));
            compare({name, " pslverr"}, 32'(!addr_in_map(paddr)), 32'(pslverr));
            if (!pwrite) begin
                if (!addr_in_map(paddr)) begin
                    compare(name, 32'd0, prdata);
                end else if (idx >= 0) begin
                    if (exp_known[idx]) begin
                        compare(name, exp_words[idx], prdata);
                    end
                end else begin
                    case (paddr)
                        ADDR_STATUS: if (status_chk) compare(name, 32'(exp_status), prdata);
                        ADDR_FLAGS:  if (res_known) compare(name, 32'(exp_res.collision), prdata);
                        ADDR_DEPTH:  if (res_known) compare(name, exp_res.depth, prdata);
                        ADDR_NORMAL: begin
                            if (res_known) begin
                                compare(name, {exp_res.normal.y, exp_res.normal.x}, prdata);
                            end
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

endmodule

// File: dv/tb_collision.sv
`timescale 1ns/1ps

module tb_collision
    import obb_pkg::*;
();

    localparam int    CLK_PERIOD = 40;
    localparam int    VEC_WORDS  = 15;
    localparam int    MAX_VECS   = 16;
    localparam int    MEM_WORDS  = 1 + MAX_VECS * VEC_WORDS;
    localparam string VEC_FILE   = "dv/collision_input.dat";

    logic                         clk;
    logic                         rst_n;
    logic                         psel;
    logic                         penable;
    logic                         pwrite;
    logic [APB_ADDR_W-1:0]        paddr;
    logic [APB_DATA_W-1:0]        pwdata;
    logic [APB_DATA_W-1:0]        prdata;
    logic                         pready;
    logic                         pslverr;
    logic [31:0]                  vec_mem [MEM_WORDS];
    logic [2*BOX_WORDS-1:0][31:0] exp_words;
    logic [2*BOX_WORDS-1:0]       exp_known;
    result_t                      exp_res;
    logic                         res_known;
    logic                         status_chk;
    logic [1:0]                   exp_status;
    int                           pass_count;
    int                           fail_count;
    int                           num_vecs;
    int                           cycle_limit = 0;
    int                           cycle_count = 0;
    int                           test_idx = 0;
    int                           fails_before = 0;
    integer                       seed;

    collision_top dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    collision_checker chk_i (
        .clk        (clk),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .exp_words  (exp_words),
        .exp_known  (exp_known),
        .exp_res    (exp_res),
        .res_known  (res_known),
        .status_chk (status_chk),
        .exp_status (exp_status),
        .pass_count (pass_count),
        .fail_count (fail_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Run timed out after %0d cycles before all tests finished", cycle_count);
            $display("Testbench failed");
            $finish;
        end
    end

    // Each transfer starts 2 ns after an edge and returns 2 ns after its completing edge
    task automatic write_reg(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #2;
        penable = 1'b1;
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic read_reg(input logic [APB_ADDR_W-1:0] addr, output logic [31:0] data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #2;
        penable = 1'b1;
        @(negedge clk);
        data = prdata;
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    function automatic logic [APB_ADDR_W-1:0] box_addr(int idx);
        if (idx < BOX_WORDS) begin
            return ADDR_BOX_A + APB_ADDR_W'(4 * idx);
        end
        return ADDR_BOX_B + APB_ADDR_W'(4 * (idx - BOX_WORDS));
    endfunction

    // Axis words keep AXIS_W bits and all others POS_W bits before sign extension
    function automatic logic [31:0] fit_word(int idx, logic [31:0] w);
        int field;
        field = idx % BOX_WORDS;
        if (field == 2 || field == 3) begin
            return {{(32 - AXIS_W){w[AXIS_W-1]}}, w[AXIS_W-1:0]};
        end
        return {{(32 - POS_W){w[POS_W-1]}}, w[POS_W-1:0]};
    endfunction

    task automatic load_box_word(input int idx, input logic [31:0] data);
        write_reg(box_addr(idx), data);
        exp_words[idx] = fit_word(idx, data);
        exp_known[idx] = 1'b1;
    endtask

    task automatic read_status(input logic [1:0] expected);
        logic [31:0] rd;
        exp_status = expected;
        status_chk = 1'b1;
        read_reg(ADDR_STATUS, rd);
        status_chk = 1'b0;
    endtask

    task automatic wait_done();
        logic [31:0] st;
        st = '0;
        while (!st[1]) begin
            read_reg(ADDR_STATUS, st);
        end
    endtask

    task automatic read_result();
        logic [31:0] rd;
        read_reg(ADDR_FLAGS, rd);
        read_reg(ADDR_DEPTH, rd);
        read_reg(ADDR_NORMAL, rd);
    endtask

    task automatic read_boxes();
        logic [31:0] rd;
        for (int i = 0; i < 2 * BOX_WORDS; i++) begin
            read_reg(box_addr(i), rd);
        end
    endtask

    task automatic end_test(input string name);
        test_idx++;
        if (fail_count == fails_before) begin
            $display("Test %0d %s: ok", test_idx, name);
        end else begin
            $display("Test %0d %s: %0d checks wrong", test_idx, name, fail_count - fails_before);
        end
        fails_before = fail_count;
    endtask

    task automatic run_vector(input int v);
        int base;
        base = 1 + v * VEC_WORDS;
        for (int i = 0; i < 2 * BOX_WORDS; i++) begin
            load_box_word(i, vec_mem[base + i]);
        end
        write_reg(ADDR_CTRL, 32'd1);
        wait_done();
        exp_res.collision = vec_mem[base + 12][0];
        exp_res.depth     = vec_mem[base + 13];
        exp_res.normal.x  = vec_mem[base + 14][15:0];
        exp_res.normal.y  = vec_mem[base + 14][31:16];
        res_known         = 1'b1;
        read_status(2'b10);
        read_result();
        end_test($sformatf("vector %0d", v));
    endtask

    task automatic run_tests();
        logic [31:0] rd;
        logic [31:0] w;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;

        // Idle state after reset with every mapped address answering without error
        res_known = 1'b1;
        read_status(2'b00);
        read_result();
        read_reg(ADDR_CTRL, rd);
        read_boxes();
        end_test("reset values");

        for (int v = 0; v < num_vecs; v++) begin
            run_vector(v);
        end

        // Second start lands while busy and must change nothing
        write_reg(ADDR_CTRL, 32'd1);
        write_reg(ADDR_CTRL, 32'd1);
        read_status(2'b01);
        wait_done();
        read_status(2'b10);
        read_result();
        end_test("start while busy");

        write_reg(12'h044, 32'h1234_5678);
        write_reg(12'h00A, 32'h0000_7777);
        write_reg(12'h0FC, 32'hFFFF_FFFF);
        read_reg(12'h048, rd);
        read_reg(12'h022, rd);
        read_boxes();
        end_test("unmapped access");

        for (int i = 0; i < 2 * BOX_WORDS; i++) begin
            w = $random(seed);
            load_box_word(i, w);
        end
        read_boxes();
        end_test("random box readback");

        $display("Checks passed %0d, failed %0d, tests run %0d", pass_count, fail_count, test_idx);
        if (fail_count == 0 && pass_count > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    initial begin
        rst_n      = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        exp_words  = '0;
        exp_known  = '0;
        exp_res    = '0;
        res_known  = 1'b0;
        status_chk = 1'b0;
        exp_status = 2'b00;
        seed       = 32'h0e01_d150;
        $readmemh(VEC_FILE, vec_mem);
        num_vecs = int'(vec_mem[0]);
        if (num_vecs < 1 || num_vecs > MAX_VECS) begin
            $display("Vector file %s holds no usable vector count", VEC_FILE);
            $display("Testbench failed");
            $finish;
        end else begin
            // Vectors plus reset, busy, unmapped and random tests and two spare
            cycle_limit = (num_vecs + 4 + 2) * 64;
            run_tests();
        end
    end

endmodule

// File: dv/collision_input.dat
// Word 0 is the number of vectors that follow
// Per vector: box A pos_x pos_y u_x u_y half_w half_h, then box B in the same order,
// then expected collision, depth (Q8.24) and normal ({y, x}, each Q2.14)
// Positions and half sizes are Q8.14, axes are Q2.14, all sign-extended to 32 bits
00000006

// Axis-aligned overlap of 0.5 along x
00000000 00000000 00004000 00000000 00004000 00004000
00006000 00000000 00004000 00000000 00004000 00004000
00000001 00800000 00004000

// Boxes just touching, depth zero still counts as contact
00000000 00000000 00004000 00000000 00004000 00004000
00008000 00000000 00004000 00000000 00004000 00004000
00000001 00000000 00004000

// B turned a quarter turn, overlap of 0.5 along y
00000000 00000000 00004000 00000000 00004000 00004000
00000000 00006000 00000000 00004000 00004000 00002000
00000001 00800000 40000000

// Axis-aligned gap of 1.0 along x
00000000 00000000 00004000 00000000 00004000 00004000
0000C000 00000000 00004000 00000000 00004000 00004000
00000000 FF000000 00004000

// B facing -x, gap of 2.0 along y
00000000 00000000 00004000 00000000 00004000 00004000
00000000 00010000 FFFFC000 00000000 00004000 00004000
00000000 FE000000 40000000

// First case shifted to negative coordinates
FFFF8000 FFFFC000 00004000 00000000 00004000 00004000
FFFFE000 FFFFC000 00004000 00000000 00004000 00004000
00000001 00800000 00004000

// File: build.f
hdl/obb_pkg.sv
hdl/obb_apb_regs.sv
hdl/corner_projector.sv
hdl/extent_fifo.sv
hdl/penetration_resolver.sv
hdl/collision_top.sv
dv/collision_checker.sv
dv/tb_collision.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --timing
TOP      = tb_collision
FILELIST = build.f
OBJ_DIR  = obj_dir

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Output goes to the console, the exit status comes from the pass message search
sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } /^Testbench passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)
